/* fpu_pkg.sv */
// ---------------------------------------------------------------------------
// shared widths, value types, op codes and credit depths of the
// half-precision lane array
// ---------------------------------------------------------------------------

package fpu_pkg;

	localparam int NUM_LANES = 3;
	localparam int LANE_LATENCY = 3;   // pipeline stages in front of the lane FIFO
	localparam int LANE_DEPTH = 4;     // lane FIFO entries, also initial credits per lane
	localparam int IN_DEPTH = 4;       // dispatcher input buffer, also producer credits
	localparam int OUT_CREDITS = 4;    // consumer slots after reset

	// half precision field constants
	localparam logic [4:0] EXP_INF = 5'h1f;
	localparam int EXP_BIAS = 15;

	typedef logic [15:0] half_t;
	typedef logic [1:0] tag_t;
	typedef logic [1:0] flags_t;     // [1] overflow, [0] inexact
	typedef logic [1:0] lane_idx_t;

	typedef enum logic [1:0] {
		op_add = 2'd0,
		op_sub = 2'd1,
		op_mul = 2'd2
	} fp_op_t;

	localparam half_t QNAN = 16'h7e00;

	typedef logic [$clog2(LANE_DEPTH)-1:0] lane_ptr_t;
	typedef logic [$clog2(LANE_DEPTH+1)-1:0] lane_cnt_t;
	typedef logic [$clog2(IN_DEPTH)-1:0] in_ptr_t;
	typedef logic [$clog2(IN_DEPTH+1)-1:0] in_cnt_t;
	typedef logic [$clog2(OUT_CREDITS+1)-1:0] out_cred_t;

endpackage

/* fpu_lane_if.sv */
// ---------------------------------------------------------------------------
// one dispatcher to lane to collector path: request side with credit
// return, response side with FIFO head and pop
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

interface fpu_lane_if;
	import fpu_pkg::*;

	logic req_valid;
	fp_op_t req_op;
	half_t req_a;
	half_t req_b;
	tag_t req_tag;
	logic req_credit;   // one pulse per freed FIFO entry

	logic rsp_valid;    // FIFO head present
	half_t rsp_result;
	flags_t rsp_flags;
	tag_t rsp_tag;
	logic rsp_pop;

	modport dispatch (output req_valid, req_op, req_a, req_b, req_tag, input req_credit);

	modport lane (input req_valid, req_op, req_a, req_b, req_tag, output req_credit,
		output rsp_valid, rsp_result, rsp_flags, rsp_tag, input rsp_pop);

	modport collect (input rsp_valid, rsp_result, rsp_flags, rsp_tag, output rsp_pop);

endinterface

/* fp_add.sv */
// ---------------------------------------------------------------------------
// combinational half-precision adder, truncating, subnormals flushed,
// overflow and inexact flags
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

module fp_add (
	input fpu_pkg::half_t a,
	input fpu_pkg::half_t b,
	output fpu_pkg::half_t sum,
	output fpu_pkg::flags_t flags
);
	import fpu_pkg::*;

	logic a_nan, b_nan, a_inf, b_inf;
	logic flush_in;
	logic [10:0] sig_a, sig_b, sig_big, sig_small;
	logic [4:0] e_big, e_small, diff;
	logic s_big, s_small;
	logic [47:0] small_wide;
	logic [23:0] big_x, small_x;
	logic sticky;
	logic [24:0] raw, norm;
	logic [4:0] lz;
	logic signed [6:0] e_res;

	always_comb
	begin
		a_nan = (a[14:10] == EXP_INF) && (a[9:0] != '0);
		b_nan = (b[14:10] == EXP_INF) && (b[9:0] != '0);
		a_inf = (a[14:10] == EXP_INF) && (a[9:0] == '0);
		b_inf = (b[14:10] == EXP_INF) && (b[9:0] == '0);

		// exponent 0 counts as zero, dropped subnormal bits make it inexact
		sig_a = (a[14:10] == '0) ? '0 : {1'b1, a[9:0]};
		sig_b = (b[14:10] == '0) ? '0 : {1'b1, b[9:0]};
		flush_in = ((a[14:10] == '0) && (a[9:0] != '0)) || ((b[14:10] == '0) && (b[9:0] != '0));

		// larger magnitude goes first so the difference never goes negative
		if ({a[14:10], sig_a} >= {b[14:10], sig_b})
		begin
			e_big = a[14:10];
			sig_big = sig_a;
			s_big = a[15];
			e_small = b[14:10];
			sig_small = sig_b;
			s_small = b[15];
		end
		else
		begin
			e_big = b[14:10];
			sig_big = sig_b;
			s_big = b[15];
			e_small = a[14:10];
			sig_small = sig_a;
			s_small = a[15];
		end

		diff = e_big - e_small;
		small_wide = {sig_small, 37'b0} >> diff;
		small_x = small_wide[47:24];
		sticky = |small_wide[23:0];   // bits beyond the 13 guard bits
		big_x = {sig_big, 13'b0};

		if (s_big ^ s_small)
			raw = {1'b0, big_x} - {1'b0, small_x} - 25'(sticky);  // borrow keeps truncation exact
		else
			raw = {1'b0, big_x} + {1'b0, small_x};

		// leading-zero search, highest set bit wins
		lz = '0;
		for (int i = 0; i < 25; i++)
		begin
			if (raw[i])
				lz = 5'(24 - i);
		end
		norm = raw << lz;
		e_res = $signed({2'b0, e_big}) + 7'sd1 - $signed({2'b0, lz});

		sum = {s_big, e_res[4:0], norm[23:14]};
		flags = {1'b0, sticky | (|norm[13:0]) | flush_in};
		if (a_nan || b_nan || (a_inf && b_inf && (a[15] != b[15])))
		begin
			sum = QNAN;
			flags = '0;
		end
		else if (a_inf)
		begin
			sum = a;
			flags = '0;
		end
		else if (b_inf)
		begin
			sum = b;
			flags = '0;
		end
		else if (raw == '0)
		begin
			sum = {a[15] & b[15], 15'b0};  // -0 only from two negative zeros
			flags = {1'b0, flush_in};
		end
		else if (e_res >= 7'sd31)
		begin
			sum = {s_big, EXP_INF, 10'b0};
			flags = 2'b10;
		end
		else if (e_res <= 7'sd0)
		begin
			sum = {s_big, 15'b0};   // would be subnormal
			flags = 2'b01;
		end
	end

endmodule

/* fp_mul.sv */
// ---------------------------------------------------------------------------
// combinational half-precision multiplier, truncating, with
// overflow and inexact flags
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

module fp_mul (
	input fpu_pkg::half_t a,
	input fpu_pkg::half_t b,
	output fpu_pkg::half_t product,
	output fpu_pkg::flags_t flags
);
	import fpu_pkg::*;

	logic a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
	logic flush_in, sign, lost;
	logic [10:0] sig_a, sig_b;
	logic [21:0] prod;
	logic [9:0] mant;
	logic signed [7:0] e_res;

	always_comb
	begin
		a_nan = (a[14:10] == EXP_INF) && (a[9:0] != '0);
		b_nan = (b[14:10] == EXP_INF) && (b[9:0] != '0);
		a_inf = (a[14:10] == EXP_INF) && (a[9:0] == '0);
		b_inf = (b[14:10] == EXP_INF) && (b[9:0] == '0);
		a_zero = (a[14:10] == '0);  // subnormals included
		b_zero = (b[14:10] == '0);
		flush_in = (a_zero && (a[9:0] != '0)) || (b_zero && (b[9:0] != '0));
		sign = a[15] ^ b[15];

		sig_a = a_zero ? '0 : {1'b1, a[9:0]};
		sig_b = b_zero ? '0 : {1'b1, b[9:0]};
		prod = sig_a * sig_b;

		// significand product lies in [1,4), normalize by at most one bit
		if (prod[21])
		begin
			mant = prod[20:11];
			lost = |prod[10:0];
		end
		else
		begin
			mant = prod[19:10];
			lost = |prod[9:0];
		end
		e_res = 8'(a[14:10]) + 8'(b[14:10]) + 8'(prod[21]) - 8'(EXP_BIAS);

		product = {sign, e_res[4:0], mant};
		flags = {1'b0, lost | flush_in};
		if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero))
		begin
			product = QNAN;
			flags = '0;
		end
		else if (a_inf || b_inf)
		begin
			product = {sign, EXP_INF, 10'b0};
			flags = '0;
		end
		else if (a_zero || b_zero)
		begin
			product = {sign, 15'b0};
			flags = {1'b0, flush_in};
		end
		else if (e_res >= 8'sd31)
		begin
			product = {sign, EXP_INF, 10'b0};
			flags = 2'b10;
		end
		else if (e_res <= 8'sd0)
		begin
			product = {sign, 15'b0};
			flags = 2'b01;
		end
	end

endmodule

/* fpu_lane.sv */
// ---------------------------------------------------------------------------
// one arithmetic lane: operand conditioning, sum/product select,
// fixed-latency pipeline and result FIFO with credit return
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

module fpu_lane (
	input logic clk,
	input logic reset,
	fpu_lane_if.lane port
);
	import fpu_pkg::*;

	half_t b_cond, sum, product, sel_result;
	flags_t add_flags, mul_flags, sel_flags;

	logic stage_valid [LANE_LATENCY];
	half_t stage_result [LANE_LATENCY];
	flags_t stage_flags [LANE_LATENCY];
	tag_t stage_tag [LANE_LATENCY];

	half_t fifo_result [LANE_DEPTH];
	flags_t fifo_flags [LANE_DEPTH];
	tag_t fifo_tag [LANE_DEPTH];
	lane_ptr_t wr_ptr, rd_ptr;
	lane_cnt_t count;
	logic push;

	// subtract is an add with B's sign flipped
	assign b_cond = (port.req_op == op_sub) ? {~port.req_b[15], port.req_b[14:0]} : port.req_b;

	fp_add add_sub (.a(port.req_a), .b(b_cond), .sum(sum), .flags(add_flags));

	fp_mul multiply (.a(port.req_a), .b(port.req_b), .product(product), .flags(mul_flags));

	always_comb
	begin
		if (port.req_op == op_mul)
		begin
			sel_result = product;
			sel_flags = mul_flags;
		end
		else
		begin
			sel_result = sum;
			sel_flags = add_flags;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < LANE_LATENCY; i++)
				stage_valid[i] <= 1'b0;
		end
		else
		begin
			stage_valid[0] <= port.req_valid;
			for (int i = 1; i < LANE_LATENCY; i++)
				stage_valid[i] <= stage_valid[i-1];
		end
	end

	always_ff @(posedge clk)
	begin
		stage_result[0] <= sel_result;
		stage_flags[0] <= sel_flags;
		stage_tag[0] <= port.req_tag;
		for (int i = 1; i < LANE_LATENCY; i++)
		begin
			stage_result[i] <= stage_result[i-1];
			stage_flags[i] <= stage_flags[i-1];
			stage_tag[i] <= stage_tag[i-1];
		end
	end

	// no stall here, the dispatcher's credits reserve a FIFO slot
	assign push = stage_valid[LANE_LATENCY-1];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			fifo_result[wr_ptr] <= stage_result[LANE_LATENCY-1];
			fifo_flags[wr_ptr] <= stage_flags[LANE_LATENCY-1];
			fifo_tag[wr_ptr] <= stage_tag[LANE_LATENCY-1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			port.req_credit <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == lane_ptr_t'(LANE_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (port.rsp_pop)
				rd_ptr <= (rd_ptr == lane_ptr_t'(LANE_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			if (push && !port.rsp_pop)
				count <= count + 1'b1;
			else if (!push && port.rsp_pop)
				count <= count - 1'b1;
			port.req_credit <= port.rsp_pop;   // slot freed, credit back
		end
	end

	assign port.rsp_valid = (count != '0);
	assign port.rsp_result = fifo_result[rd_ptr];
	assign port.rsp_flags = fifo_flags[rd_ptr];
	assign port.rsp_tag = fifo_tag[rd_ptr];

endmodule

/* fpu_dispatch.sv */
// ---------------------------------------------------------------------------
// input buffer with producer credit return, and round-robin issue
// to the lanes under per-lane credits
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

module fpu_dispatch (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input fpu_pkg::fp_op_t in_op,
	input fpu_pkg::half_t in_a,
	input fpu_pkg::half_t in_b,
	input fpu_pkg::tag_t in_tag,
	output logic in_credit,
	fpu_lane_if.dispatch lanes [fpu_pkg::NUM_LANES]
);
	import fpu_pkg::*;

	fp_op_t buf_op [IN_DEPTH];
	half_t buf_a [IN_DEPTH];
	half_t buf_b [IN_DEPTH];
	tag_t buf_tag [IN_DEPTH];
	in_ptr_t wr_ptr, rd_ptr;
	in_cnt_t count;
	lane_cnt_t lane_cred [NUM_LANES];
	logic credit_in [NUM_LANES];
	logic issue_lane [NUM_LANES];
	lane_idx_t rr_ptr;
	logic issue;

	// strict rotation, waits on the pointed lane even if others have room
	assign issue = (count != '0) && (lane_cred[rr_ptr] != '0);

	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		assign issue_lane[g] = issue && (rr_ptr == lane_idx_t'(g));
		assign lanes[g].req_valid = issue_lane[g];
		assign lanes[g].req_op = buf_op[rd_ptr];
		assign lanes[g].req_a = buf_a[rd_ptr];
		assign lanes[g].req_b = buf_b[rd_ptr];
		assign lanes[g].req_tag = buf_tag[rd_ptr];
		assign credit_in[g] = lanes[g].req_credit;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)   // producer only sends with a credit in hand
		begin
			buf_op[wr_ptr] <= in_op;
			buf_a[wr_ptr] <= in_a;
			buf_b[wr_ptr] <= in_b;
			buf_tag[wr_ptr] <= in_tag;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rr_ptr <= '0;
			in_credit <= 1'b0;
			for (int i = 0; i < NUM_LANES; i++)
				lane_cred[i] <= lane_cnt_t'(LANE_DEPTH);
		end
		else
		begin
			if (in_valid)
				wr_ptr <= (wr_ptr == in_ptr_t'(IN_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (issue)
			begin
				rd_ptr <= (rd_ptr == in_ptr_t'(IN_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
				rr_ptr <= (rr_ptr == lane_idx_t'(NUM_LANES-1)) ? '0 : rr_ptr + 1'b1;
			end
			if (in_valid && !issue)
				count <= count + 1'b1;
			else if (!in_valid && issue)
				count <= count - 1'b1;
			in_credit <= issue;   // entry left the buffer
			for (int i = 0; i < NUM_LANES; i++)
			begin
				if (credit_in[i] && !issue_lane[i])
					lane_cred[i] <= lane_cred[i] + 1'b1;
				else if (!credit_in[i] && issue_lane[i])
					lane_cred[i] <= lane_cred[i] - 1'b1;
			end
		end
	end

endmodule

/* fpu_collect.sv */
// ---------------------------------------------------------------------------
// in-order round-robin drain of the lane FIFOs, registered output
// under consumer credits
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

module fpu_collect (
	input logic clk,
	input logic reset,
	fpu_lane_if.collect lanes [fpu_pkg::NUM_LANES],
	output logic out_valid,
	output fpu_pkg::half_t out_result,
	output fpu_pkg::flags_t out_flags,
	output fpu_pkg::tag_t out_tag,
	input logic out_credit
);
	import fpu_pkg::*;

	logic head_valid [NUM_LANES];
	half_t head_result [NUM_LANES];
	flags_t head_flags [NUM_LANES];
	tag_t head_tag [NUM_LANES];
	lane_idx_t rr_ptr;
	out_cred_t out_cred;
	logic credit_ok;
	logic pop;

	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		assign head_valid[g] = lanes[g].rsp_valid;
		assign head_result[g] = lanes[g].rsp_result;
		assign head_flags[g] = lanes[g].rsp_flags;
		assign head_tag[g] = lanes[g].rsp_tag;
		assign lanes[g].rsp_pop = pop && (rr_ptr == lane_idx_t'(g));
	end

	// the credit is spent on the out_valid cycle, so a pending output
	// already holds one of the counted credits
	assign credit_ok = out_valid ? (out_cred > out_cred_t'(1)) : (out_cred != '0);
	assign pop = head_valid[rr_ptr] && credit_ok;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			rr_ptr <= '0;
			out_cred <= out_cred_t'(OUT_CREDITS);
		end
		else
		begin
			out_valid <= pop;
			if (pop)
				rr_ptr <= (rr_ptr == lane_idx_t'(NUM_LANES-1)) ? '0 : rr_ptr + 1'b1;
			if (out_credit && !out_valid)
				out_cred <= out_cred + 1'b1;
			else if (!out_credit && out_valid)
				out_cred <= out_cred - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			out_result <= head_result[rr_ptr];
			out_flags <= head_flags[rr_ptr];
			out_tag <= head_tag[rr_ptr];
		end
	end

endmodule

/* fpu_array.sv */
// ---------------------------------------------------------------------------
// top level: dispatcher, generated lanes and in-order collector joined
// by an array of lane interfaces
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

module fpu_array (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input fpu_pkg::fp_op_t in_op,
	input fpu_pkg::half_t in_a,
	input fpu_pkg::half_t in_b,
	input fpu_pkg::tag_t in_tag,
	output logic in_credit,
	output logic out_valid,
	output fpu_pkg::half_t out_result,
	output fpu_pkg::flags_t out_flags,
	output fpu_pkg::tag_t out_tag,
	input logic out_credit
);
	import fpu_pkg::*;

	fpu_lane_if lane_bus [NUM_LANES] ();

	fpu_dispatch dispatch (
		.clk,
		.reset,
		.in_valid,
		.in_op,
		.in_a,
		.in_b,
		.in_tag,
		.in_credit,
		.lanes(lane_bus)
	);

	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		fpu_lane lane (.clk, .reset, .port(lane_bus[g]));
	end

	// drains in the same rotation the dispatcher issues in
	fpu_collect collect (
		.clk,
		.reset,
		.lanes(lane_bus),
		.out_valid,
		.out_result,
		.out_flags,
		.out_tag,
		.out_credit
	);

endmodule

/* fpu_array_checker.sv */
// ---------------------------------------------------------------------------
// bound protocol assertions for the lane array: reset state, quiet
// outputs before the first input, producer and consumer credit rules
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

module fpu_array_checker (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic in_credit,
	input logic out_valid,
	input logic out_credit
);
	import fpu_pkg::*;

	int error_count;
	logic seen_input;   // any input accepted since reset
	int accepted;
	int returned;
	int out_avail;      // consumer slots the collector may still fill

	initial
		error_count = 0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			seen_input <= 1'b0;
			accepted <= 0;
			returned <= 0;
			out_avail <= OUT_CREDITS;
		end
		else
		begin
			if (in_valid)
				seen_input <= 1'b1;
			accepted <= accepted + int'(in_valid);
			returned <= returned + int'(in_credit);
			out_avail <= out_avail + int'(out_credit) - int'(out_valid);
		end
	end

	reset_clears: assert property (@(posedge clk) reset |=> (!out_valid && !in_credit))
	else
	begin
		$error("out_valid or in_credit high right after reset");
		error_count++;
	end

	quiet_before_input: assert property (@(posedge clk) disable iff (reset)
		!seen_input |-> (!out_valid && !in_credit))
	else
	begin
		$error("output activity before any input was accepted");
		error_count++;
	end

	out_needs_credit: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> (out_avail > 0))
	else
	begin
		$error("out_valid asserted with no consumer credit left");
		error_count++;
	end

	in_credit_bounded: assert property (@(posedge clk) disable iff (reset)
		in_credit |-> (returned < accepted))
	else
	begin
		$error("in_credit returned without an input to match it");
		error_count++;
	end

endmodule

/* fpu_array_tb.sv */
// ---------------------------------------------------------------------------
// testbench for the lane array: clock and reset, credit-obeying producer,
// LCG-paced consumer, exact reference model, ordered scoreboard, watchdog
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

module fpu_array_tb;
	import fpu_pkg::*;

	localparam int NUM_DIRECTED = 10;
	localparam int NUM_RANDOM = 60;   // per credit-rate phase
	localparam int TOTAL_OPS = NUM_DIRECTED + 2 * NUM_RANDOM;
	localparam int WATCHDOG_CYCLES = TOTAL_OPS * 40 + 200;

	logic clk;
	logic reset;
	logic in_valid;
	fp_op_t in_op;
	half_t in_a;
	half_t in_b;
	tag_t in_tag;
	logic in_credit;
	logic out_valid;
	half_t out_result;
	flags_t out_flags;
	tag_t out_tag;
	logic out_credit = 1'b0;

	int credits;                   // producer side input credits
	int credit_rate;               // consumer credit return, percent per cycle
	int occupied = 0;              // consumer slots holding a result
	logic [31:0] stim_state;
	logic [31:0] cons_state = 32'h3890;
	logic [19:0] expect_q [$];     // {tag, flags, result} in issue order

	fpu_array dut0 (.*);

	bind fpu_array fpu_array_checker checks (.clk, .reset, .in_valid, .in_credit,
		.out_valid, .out_credit);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// exact fixed point value with frac fraction bits to {flags, half}, truncating
	function automatic logic [17:0] fixed_to_half(input longint value, input int frac);
		logic sign;
		longint mag;
		int msb;
		int exp_val;
		logic [9:0] mant;
		logic lost;
		sign = (value < 0);
		mag = sign ? -value : value;
		if (mag == 0)
			return 18'h0;
		msb = 0;
		for (int i = 0; i < 63; i++)
		begin
			if (mag[i])
				msb = i;
		end
		exp_val = msb - frac + 15;
		if (msb >= 10)
		begin
			mant = 10'(mag >> (msb - 10));   // hidden bit falls off the top
			lost = (mag & ((64'sd1 <<< (msb - 10)) - 1)) != 0;
		end
		else
		begin
			mant = 10'(mag << (10 - msb));
			lost = 1'b0;
		end
		if (exp_val >= 31)
			return {2'b10, sign, 5'h1f, 10'h0};
		if (exp_val <= 0)
			return {2'b01, sign, 15'h0};
		return {1'b0, lost, sign, 5'(exp_val), mant};
	endfunction

	// operands in units of 1/2, products in units of 1/4
	function automatic logic [19:0] expected_of(input fp_op_t op, input longint va,
		input longint vb, input tag_t tag);
		logic [17:0] res;
		if (op == op_mul)
		begin
			res = fixed_to_half(va * vb, 2);
			if (va * vb == 0)
				res[15] = (va < 0) ^ (vb < 0);   // signed zero from the sign xor
		end
		else if (op == op_sub)
			res = fixed_to_half(va - vb, 1);
		else
			res = fixed_to_half(va + vb, 1);
		return {tag, res};
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		if (in_credit)
			credits++;
		in_valid <= 1'b0;
	endtask

	task automatic send_op(input fp_op_t op, input longint va, input longint vb,
		input tag_t tag);
		logic [17:0] ha;
		logic [17:0] hb;
		ha = fixed_to_half(va, 1);
		hb = fixed_to_half(vb, 1);
		next_cycle();
		while (credits == 0)
			next_cycle();
		in_valid <= 1'b1;
		in_op <= op;
		in_a <= ha[15:0];
		in_b <= hb[15:0];
		in_tag <= tag;
		credits--;
		expect_q.push_back(expected_of(op, va, vb, tag));
	endtask

	task automatic send_random(input int count);
		fp_op_t op;
		longint va;
		longint vb;
		for (int i = 0; i < count; i++)
		begin
			stim_state = lcg_next(stim_state);
			op = fp_op_t'(2'((stim_state >> 16) % 3));
			va = longint'((stim_state >> 4) % 257) - 128;   // halves within +-64
			stim_state = lcg_next(stim_state);
			vb = longint'((stim_state >> 4) % 257) - 128;
			send_op(op, va, vb, tag_t'(stim_state >> 24));
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = op_add;
		in_a = '0;
		in_b = '0;
		in_tag = '0;
		credits = IN_DEPTH;
		credit_rate = 90;
		stim_state = 32'h3890;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		repeat (4) next_cycle();   // idle, outputs must stay quiet

		send_op(op_add, 6, 8, 2'd0);          // 3 + 4
		send_op(op_add, -5, -7, 2'd1);        // -2.5 + -3.5
		send_op(op_sub, 10, 18, 2'd2);        // 5 - 9
		send_op(op_sub, 27, 27, 2'd3);        // x - x gives +0
		send_op(op_sub, -12, -12, 2'd0);
		send_op(op_mul, -14, 12, 2'd1);       // -7 * 6
		send_op(op_mul, -16, -1, 2'd2);       // -8 * -0.5
		send_op(op_mul, 0, -10, 2'd3);        // -0
		send_op(op_add, 120000, 120000, 2'd2);  // 60000 + 60000 overflows
		send_op(op_mul, 600, 600, 2'd3);      // 300 * 300 overflows

		send_random(NUM_RANDOM);
		credit_rate <= 30;
		send_random(NUM_RANDOM);
		next_cycle();

		while (expect_q.size() != 0)
			@(posedge clk);
		repeat (20) @(posedge clk);
		if (expect_q.size() == 0 && dut0.checks.error_count == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			$display("results missing or a protocol assertion failed at the end of the run");
			$display("Checks failed");
			$fatal(1);
		end
	end

	// consumer: check each result, free slots on LCG-chosen cycles
	always @(posedge clk)
	begin
		logic [19:0] want;
		int held;
		held = occupied;
		out_credit <= 1'b0;
		if (!reset)
		begin
			if (out_valid)
			begin
				assert (expect_q.size() != 0)
				else
				begin
					$display("error: %0d ns output with no operation outstanding, tag %0d",
						$time, out_tag);
					$display("Checks failed");
					$fatal(1);
				end
				want = expect_q.pop_front();
				assert ({out_tag, out_flags, out_result} == want)
				else
				begin
					$display("error: %0d ns got tag %0d result %h flags %b, want tag %0d %h %b",
						$time, out_tag, out_result, out_flags, want[19:18], want[15:0],
						want[17:16]);
					$display("Checks failed");
					$fatal(1);
				end
				held++;
			end
			cons_state = lcg_next(cons_state);
			if (held > 0 && ((cons_state >> 16) % 100) < credit_rate)
			begin
				out_credit <= 1'b1;
				held--;
			end
			occupied = held;
		end
	end

	always @(posedge clk)
	begin
		if (dut0.checks.error_count != 0)
		begin
			$display("a protocol assertion in the bound checker failed");
			$display("Checks failed");
			$fatal(1);
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$fatal(1);
	end

endmodule

/* fpu_array.f */
fpu_pkg.sv
fpu_lane_if.sv
fp_add.sv
fp_mul.sv
fpu_lane.sv
fpu_dispatch.sv
fpu_collect.sv
fpu_array.sv
fpu_array_checker.sv
fpu_array_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP := fpu_array_tb
FILELIST := fpu_array.f
BUILD_DIR := obj_dir
PASS_MSG := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
